// ==== rtl/i3c_daa_pkg.sv ====
package i3c_daa_pkg;

  // Broadcast address used by ENTDAA
  localparam logic [6:0] RsvdAddr = 7'h7e;

  // PID + BCR + DCR
  localparam logic [6:0] DevIdBits = 7'd64;

  // Reserved byte reads as addr + rnw, address byte as addr + parity
  typedef struct packed {
    logic [6:0] addr;
    logic       par;
  } addr_par_t;

  typedef union packed {
    logic [7:0] raw;
    addr_par_t  addr_par;
  } rx_byte_u;

  typedef struct packed {
    logic scl_rise;
    logic scl_fall;
    logic rstart;
    logic stop;
    logic sda;
  } bus_evt_t;

  typedef struct packed {
    logic req_byte;
    logic req_bit;
  } rx_req_t;

  typedef struct packed {
    logic req_bit;
    logic value;
  } tx_req_t;

  typedef struct packed {
    logic [47:0] pid;
    logic [7:0]  bcr;
    logic [7:0]  dcr;
  } dev_id_t;

endpackage

// ==== rtl/bus_monitor.sv ====
`timescale 1ns/100ps

module bus_monitor #(
  parameter int unsigned SyncStages = 2
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  scl_i,
  input  logic                  sda_i,
  output i3c_daa_pkg::bus_evt_t evt_o
);

  logic [SyncStages-1:0] scl_sync_q;
  logic [SyncStages-1:0] sda_sync_q;
  logic                  scl_s;
  logic                  sda_s;
  logic                  scl_d_q;
  logic                  sda_d_q;
  i3c_daa_pkg::bus_evt_t evt_d;
  i3c_daa_pkg::bus_evt_t evt_q;

  assign scl_s = scl_sync_q[SyncStages-1];
  assign sda_s = sda_sync_q[SyncStages-1];

  // Idle bus is pulled high
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_sync_q <= '1;
      sda_sync_q <= '1;
      scl_d_q    <= 1'b1;
      sda_d_q    <= 1'b1;
    end else begin
      scl_sync_q <= {scl_sync_q[SyncStages-2:0], scl_i};
      sda_sync_q <= {sda_sync_q[SyncStages-2:0], sda_i};
      scl_d_q    <= scl_s;
      sda_d_q    <= sda_s;
    end
  end

  always_comb begin
    evt_d.scl_rise = scl_s & ~scl_d_q;
    evt_d.scl_fall = ~scl_s & scl_d_q;
    // SDA edges while SCL stays high
    evt_d.rstart   = scl_s & scl_d_q & sda_d_q & ~sda_s;
    evt_d.stop     = scl_s & scl_d_q & ~sda_d_q & sda_s;
    evt_d.sda      = sda_s;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      evt_q <= '0;
    end else begin
      evt_q <= evt_d;
    end
  end

  assign evt_o = evt_q;

  a_start_stop_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(evt_o.rstart && evt_o.stop));

endmodule

// ==== rtl/bus_rx.sv ====
`timescale 1ns/100ps

module bus_rx (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  i3c_daa_pkg::bus_evt_t evt_i,
  input  i3c_daa_pkg::rx_req_t  req_i,
  output i3c_daa_pkg::rx_byte_u data_o,
  output logic                  done_o
);

  logic       req_act;
  logic       req_q;
  logic       shift_en;
  logic [3:0] bit_goal;
  logic [3:0] bit_cnt_q;
  logic [7:0] shift_q;
  logic       done_q;

  assign req_act  = req_i.req_byte | req_i.req_bit;
  assign bit_goal = req_i.req_byte ? 4'd8 : 4'd1;
  assign shift_en = req_act & req_q & evt_i.scl_rise & (bit_cnt_q < bit_goal);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q     <= 1'b0;
      bit_cnt_q <= '0;
      done_q    <= 1'b0;
    end else begin
      req_q  <= req_act;
      done_q <= 1'b0;
      // New request or bus framing restarts the count
      if (evt_i.rstart || evt_i.stop || (req_act && !req_q)) begin
        bit_cnt_q <= '0;
      end else if (shift_en) begin
        bit_cnt_q <= bit_cnt_q + 4'd1;
        done_q    <= (bit_cnt_q + 4'd1 == bit_goal);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (shift_en) begin
      shift_q <= {shift_q[6:0], evt_i.sda};
    end
  end

  assign data_o.raw = shift_q;
  assign done_o     = done_q;

endmodule

// ==== rtl/bus_tx.sv ====
`timescale 1ns/100ps

module bus_tx (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  i3c_daa_pkg::bus_evt_t evt_i,
  input  i3c_daa_pkg::tx_req_t  req_i,
  output logic                  sda_oe_o,
  output logic                  done_o,
  output logic                  arb_lost_o
);

  logic bit_act_q;
  logic bit_val_q;
  logic oe_q;
  logic mismatch;

  // Sent a released 1 but someone else held SDA low
  assign mismatch   = bit_val_q & ~evt_i.sda;
  assign done_o     = bit_act_q & evt_i.scl_rise & ~mismatch;
  assign arb_lost_o = bit_act_q & evt_i.scl_rise & mismatch;
  assign sda_oe_o   = oe_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bit_act_q <= 1'b0;
      oe_q      <= 1'b0;
    end else if (evt_i.rstart || evt_i.stop) begin
      bit_act_q <= 1'b0;
      oe_q      <= 1'b0;
    end else if (evt_i.scl_fall) begin
      // SDA only changes while SCL is low, drive holds through the high phase
      bit_act_q <= req_i.req_bit;
      oe_q      <= req_i.req_bit & ~req_i.value;
    end else if (arb_lost_o) begin
      bit_act_q <= 1'b0;
      oe_q      <= 1'b0;
    end else if (done_o) begin
      bit_act_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (evt_i.scl_fall) begin
      bit_val_q <= req_i.value;
    end
  end

  a_done_arb_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(done_o && arb_lost_o));

endmodule

// ==== rtl/ccc_entdaa.sv ====
`timescale 1ns/100ps

module ccc_entdaa (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  i3c_daa_pkg::dev_id_t  dev_id_i,
  input  logic                  start_daa_i,
  input  logic                  process_virtual_i,
  output logic                  done_daa_o,
  input  i3c_daa_pkg::bus_evt_t evt_i,
  output i3c_daa_pkg::rx_req_t  rx_req_o,
  input  i3c_daa_pkg::rx_byte_u rx_data_i,
  input  logic                  rx_done_i,
  output i3c_daa_pkg::tx_req_t  tx_req_o,
  input  logic                  tx_done_i,
  input  logic                  arb_lost_i,
  output logic [6:0]            address_o,
  output logic                  address_valid_o
);

  typedef enum logic [3:0] {
    Idle            = 4'h0,
    WaitStart       = 4'h1,
    ReceiveRsvdByte = 4'h2,
    AckRsvdByte     = 4'h3,
    SendNack        = 4'h4,
    SendID          = 4'h5,
    PrepareIDBit    = 4'h6,
    SendIDBit       = 4'h7,
    LostArbitration = 4'h8,
    ReceiveAddr     = 4'h9,
    AckAddr         = 4'ha,
    Done            = 4'hb,
    Error           = 4'hc
  } state_e;

  state_e      state_q;
  state_e      state_d;
  logic [6:0]  id_bit_cnt_q;
  logic        load_id_cnt;
  logic        tick_id_cnt;
  logic        rsvd_ok;
  logic        parity_ok;
  logic        abort;
  logic [63:0] id_bits;

  assign id_bits   = dev_id_i;
  assign rsvd_ok   = (rx_data_i.addr_par.addr == i3c_daa_pkg::RsvdAddr) &&
                     rx_data_i.addr_par.par;
  // Odd parity over address and parity bit
  assign parity_ok = ^rx_data_i.raw;
  assign abort     = evt_i.stop && !(state_q inside {Idle, Done, Error});

  // Failed rounds end through Error, good or aborted ones through Done
  assign done_daa_o = (state_q == Done) || (state_q == Error);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      id_bit_cnt_q <= '0;
    end else if (load_id_cnt) begin
      id_bit_cnt_q <= i3c_daa_pkg::DevIdBits;
    end else if (tick_id_cnt) begin
      id_bit_cnt_q <= id_bit_cnt_q - 7'd1;
    end
  end

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      Idle: begin
        if (start_daa_i) state_d = WaitStart;
      end
      WaitStart: begin
        if (evt_i.rstart) state_d = ReceiveRsvdByte;
      end
      ReceiveRsvdByte: begin
        if (rx_done_i) state_d = rsvd_ok ? AckRsvdByte : SendNack;
      end
      AckRsvdByte: begin
        if (tx_done_i) state_d = SendID;
      end
      SendNack: begin
        if (tx_done_i) state_d = Error;
      end
      SendID: begin
        state_d = PrepareIDBit;
      end
      PrepareIDBit: begin
        state_d = (id_bit_cnt_q != '0) ? SendIDBit : Error;
      end
      SendIDBit: begin
        if (arb_lost_i) begin
          state_d = LostArbitration;
        end else if (tx_done_i) begin
          state_d = (id_bit_cnt_q == '0) ? ReceiveAddr : PrepareIDBit;
        end
      end
      LostArbitration: begin
        state_d = Error;
      end
      ReceiveAddr: begin
        if (rx_done_i) state_d = parity_ok ? AckAddr : SendNack;
      end
      AckAddr: begin
        if (tx_done_i) state_d = Done;
      end
      Done: begin
        state_d = Idle;
      end
      Error: begin
        state_d = Idle;
      end
      default: begin
        state_d = Idle;
      end
    endcase
  end

  always_comb begin
    rx_req_o        = '0;
    tx_req_o        = '0;
    load_id_cnt     = 1'b0;
    tick_id_cnt     = 1'b0;
    address_o       = '0;
    address_valid_o = 1'b0;
    unique case (state_q)
      ReceiveRsvdByte: begin
        rx_req_o.req_byte = 1'b1;
      end
      AckRsvdByte, AckAddr: begin
        tx_req_o.req_bit = 1'b1;
        tx_req_o.value   = 1'b0;
      end
      SendNack: begin
        tx_req_o.req_bit = 1'b1;
        tx_req_o.value   = 1'b1;
      end
      SendID: begin
        load_id_cnt = 1'b1;
      end
      PrepareIDBit: begin
        tick_id_cnt = 1'b1;
      end
      SendIDBit: begin
        // Counter already ticked, so 63 selects the PID MSB
        tx_req_o.req_bit = 1'b1;
        tx_req_o.value   = id_bits[id_bit_cnt_q[5:0]];
      end
      ReceiveAddr: begin
        rx_req_o.req_byte = 1'b1;
        if (rx_done_i && parity_ok) begin
          address_o       = rx_data_i.addr_par.addr;
          address_valid_o = 1'b1;
        end
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
    end else if (abort) begin
      state_q <= Done;
    end else begin
      state_q <= state_d;
    end
  end

  a_addr_in_rx: assert property (@(posedge clk_i) disable iff (!rst_ni)
    address_valid_o |-> (state_q == ReceiveAddr));

endmodule

// ==== rtl/daa_addr_table.sv ====
`timescale 1ns/100ps

module daa_addr_table (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 start_i,
  input  logic                 virt_enable_i,
  input  i3c_daa_pkg::dev_id_t main_id_i,
  input  i3c_daa_pkg::dev_id_t virt_id_i,
  input  logic [6:0]           address_i,
  input  logic                 address_valid_i,
  output logic                 start_o,
  output logic                 process_virtual_o,
  output i3c_daa_pkg::dev_id_t dev_id_o,
  output logic [6:0]           main_addr_o,
  output logic                 main_valid_o,
  output logic [6:0]           virt_addr_o,
  output logic                 virt_valid_o
);

  logic [6:0] main_addr_q;
  logic [6:0] virt_addr_q;
  logic       main_valid_q;
  logic       virt_valid_q;

  // Main identity first, virtual one once main holds an address
  assign process_virtual_o = main_valid_q;
  assign dev_id_o          = main_valid_q ? virt_id_i : main_id_i;
  assign start_o           = start_i & (~main_valid_q | (virt_enable_i & ~virt_valid_q));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      main_valid_q <= 1'b0;
      virt_valid_q <= 1'b0;
    end else if (address_valid_i) begin
      if (process_virtual_o) virt_valid_q <= 1'b1;
      else main_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (address_valid_i) begin
      if (process_virtual_o) virt_addr_q <= address_i;
      else main_addr_q <= address_i;
    end
  end

  assign main_addr_o  = main_addr_q;
  assign main_valid_o = main_valid_q;
  assign virt_addr_o  = virt_addr_q;
  assign virt_valid_o = virt_valid_q;

endmodule

// ==== rtl/i3c_daa_target.sv ====
`timescale 1ns/100ps

module i3c_daa_target #(
  parameter int unsigned SyncStages = 2
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        scl_i,
  input  logic        sda_i,
  output logic        sda_oe_o,
  input  logic        start_daa_i,
  input  logic        virt_enable_i,
  input  logic [47:0] pid_i,
  input  logic [7:0]  bcr_i,
  input  logic [7:0]  dcr_i,
  input  logic [47:0] virt_pid_i,
  input  logic [7:0]  virt_bcr_i,
  input  logic [7:0]  virt_dcr_i,
  output logic [6:0]  addr_o,
  output logic        addr_valid_o,
  output logic [6:0]  virt_addr_o,
  output logic        virt_addr_valid_o,
  output logic        daa_done_o
);

  i3c_daa_pkg::bus_evt_t evt;
  i3c_daa_pkg::rx_req_t  rx_req;
  i3c_daa_pkg::rx_byte_u rx_data;
  i3c_daa_pkg::tx_req_t  tx_req;
  i3c_daa_pkg::dev_id_t  main_id;
  i3c_daa_pkg::dev_id_t  virt_id;
  i3c_daa_pkg::dev_id_t  dev_id;
  logic                  rx_done;
  logic                  tx_done;
  logic                  arb_lost;
  logic                  start_daa;
  logic                  process_virtual;
  logic [6:0]            address;
  logic                  address_valid;

  assign main_id = {pid_i, bcr_i, dcr_i};
  assign virt_id = {virt_pid_i, virt_bcr_i, virt_dcr_i};

  bus_monitor #(
    .SyncStages(SyncStages)
  ) u_bus_monitor (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .scl_i (scl_i),
    .sda_i (sda_i),
    .evt_o (evt)
  );

  bus_rx u_bus_rx (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .evt_i (evt),
    .req_i (rx_req),
    .data_o(rx_data),
    .done_o(rx_done)
  );

  bus_tx u_bus_tx (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .evt_i     (evt),
    .req_i     (tx_req),
    .sda_oe_o  (sda_oe_o),
    .done_o    (tx_done),
    .arb_lost_o(arb_lost)
  );

  ccc_entdaa u_ccc_entdaa (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .dev_id_i         (dev_id),
    .start_daa_i      (start_daa),
    .process_virtual_i(process_virtual),
    .done_daa_o       (daa_done_o),
    .evt_i            (evt),
    .rx_req_o         (rx_req),
    .rx_data_i        (rx_data),
    .rx_done_i        (rx_done),
    .tx_req_o         (tx_req),
    .tx_done_i        (tx_done),
    .arb_lost_i       (arb_lost),
    .address_o        (address),
    .address_valid_o  (address_valid)
  );

  daa_addr_table u_daa_addr_table (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .start_i          (start_daa_i),
    .virt_enable_i    (virt_enable_i),
    .main_id_i        (main_id),
    .virt_id_i        (virt_id),
    .address_i        (address),
    .address_valid_i  (address_valid),
    .start_o          (start_daa),
    .process_virtual_o(process_virtual),
    .dev_id_o         (dev_id),
    .main_addr_o      (addr_o),
    .main_valid_o     (addr_valid_o),
    .virt_addr_o      (virt_addr_o),
    .virt_valid_o     (virt_addr_valid_o)
  );

endmodule

// ==== tests/tb_i3c_daa_target.sv ====
`timescale 1ns/100ps

module tb_i3c_daa_target;

  localparam int NumRows     = 11;
  localparam int RoundClocks = 1800;
  localparam int NoStop      = 64;

  typedef struct {
    logic        reset_before;
    logic        virt_en;
    logic [63:0] main_id;
    logic [63:0] virt_id;
    logic [7:0]  rsvd_byte;
    logic        comp_en;
    logic [63:0] comp_id;
    logic [6:0]  addr;
    logic        bad_par;
    int          stop_at;
    logic        answer_virt;
    logic        rsvd_acked;
    logic        addr_acked;
    int          done_pulses;
    logic        main_valid;
    logic [6:0]  main_addr;
    logic        virt_valid;
    logic [6:0]  virt_addr;
  } row_t;

  logic        clk_i;
  logic        rst_ni;
  logic        scl;
  logic        sda_ctrl;
  logic        sda_bus;
  logic        sda_oe;
  logic        start_daa;
  logic        virt_en;
  logic [63:0] main_id;
  logic [63:0] virt_id;
  logic [6:0]  addr;
  logic        addr_valid;
  logic [6:0]  virt_addr;
  logic        virt_addr_valid;
  logic        daa_done;
  integer      seed = 32'h30c9_f1c8;
  int          done_count = 0;
  row_t        rows [NumRows];

  // Wired-AND bus, target pulls low when sda_oe is set
  assign sda_bus = sda_ctrl & ~sda_oe;

  i3c_daa_target #(
    .SyncStages(2)
  ) u_i3c_daa_target (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .scl_i            (scl),
    .sda_i            (sda_bus),
    .sda_oe_o         (sda_oe),
    .start_daa_i      (start_daa),
    .virt_enable_i    (virt_en),
    .pid_i            (main_id[63:16]),
    .bcr_i            (main_id[15:8]),
    .dcr_i            (main_id[7:0]),
    .virt_pid_i       (virt_id[63:16]),
    .virt_bcr_i       (virt_id[15:8]),
    .virt_dcr_i       (virt_id[7:0]),
    .addr_o           (addr),
    .addr_valid_o     (addr_valid),
    .virt_addr_o      (virt_addr),
    .virt_addr_valid_o(virt_addr_valid),
    .daa_done_o       (daa_done)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    if (daa_done === 1'b1) done_count++;
  end

  initial begin
    repeat (NumRows * RoundClocks * 2) @(posedge clk_i);
    $display("Timeout: the ENTDAA rounds did not finish in the expected time");
    $display("TEST FAILED");
    $fatal(1, "watchdog expired");
  end

  task automatic wait_clocks(input int n);
    repeat (n) @(posedge clk_i);
    #5;
  endtask

  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("error at %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
      $display("TEST FAILED");
      $fatal(1, "mismatch");
    end
  endtask

  task automatic apply_reset();
    wait_clocks(1);
    rst_ni = 1'b0;
    wait_clocks(2);
    rst_ni = 1'b1;
    check_value(64'(sda_oe), 64'd0, "sda_oe after reset");
    check_value(64'(addr_valid), 64'd0, "main slot after reset");
    check_value(64'(virt_addr_valid), 64'd0, "virtual slot after reset");
  endtask

  // One SCL period, SDA set in the low phase and read late in the high phase
  task automatic clock_bit(input logic drive, output logic seen);
    wait_clocks(1);
    scl = 1'b0;
    wait_clocks(2);
    sda_ctrl = drive;
    wait_clocks(8);
    scl = 1'b1;
    wait_clocks(10);
    seen = sda_bus;
  endtask

  task automatic issue_start();
    wait_clocks(1);
    sda_ctrl = 1'b0;
    wait_clocks(10);
  endtask

  task automatic issue_stop();
    wait_clocks(1);
    scl = 1'b0;
    wait_clocks(2);
    sda_ctrl = 1'b0;
    wait_clocks(8);
    scl = 1'b1;
    wait_clocks(10);
    sda_ctrl = 1'b1;
    wait_clocks(10);
  endtask

  // SCL stays high, so SDA falls then rises on a released bus
  task automatic break_with_stop();
    wait_clocks(1);
    sda_ctrl = 1'b0;
    wait_clocks(10);
    sda_ctrl = 1'b1;
    wait_clocks(10);
  endtask

  task automatic base_row(output row_t r, input logic rst, input logic ven,
                          input logic [6:0] a);
    r.reset_before = rst;
    r.virt_en      = ven;
    r.main_id      = {$random(seed), $random(seed)};
    r.virt_id      = {$random(seed), $random(seed)};
    r.rsvd_byte    = 8'hfd;
    r.comp_en      = 1'b0;
    r.comp_id      = '1;
    r.addr         = a;
    r.bad_par      = 1'b0;
    r.stop_at      = NoStop;
    r.answer_virt  = 1'b0;
    r.rsvd_acked   = 1'b1;
    r.addr_acked   = 1'b1;
    r.done_pulses  = 1;
    r.main_valid   = 1'b0;
    r.main_addr    = '0;
    r.virt_valid   = 1'b0;
    r.virt_addr    = '0;
  endtask

  task automatic build_table();
    base_row(rows[0], 1'b0, 1'b0, 7'h21);
    rows[0].main_valid = 1'b1;
    rows[0].main_addr  = 7'h21;
    // Main slot taken and no virtual identity, start is not forwarded
    base_row(rows[1], 1'b0, 1'b0, 7'h33);
    rows[1].rsvd_acked  = 1'b0;
    rows[1].addr_acked  = 1'b0;
    rows[1].done_pulses = 0;
    rows[1].main_valid  = 1'b1;
    rows[1].main_addr   = 7'h21;
    base_row(rows[2], 1'b1, 1'b0, 7'h12);
    rows[2].rsvd_byte  = 8'hfc;
    rows[2].rsvd_acked = 1'b0;
    rows[2].addr_acked = 1'b0;
    base_row(rows[3], 1'b0, 1'b0, 7'h12);
    rows[3].rsvd_byte  = 8'hb7;
    rows[3].rsvd_acked = 1'b0;
    rows[3].addr_acked = 1'b0;
    base_row(rows[4], 1'b0, 1'b0, 7'h4c);
    rows[4].bad_par    = 1'b1;
    rows[4].addr_acked = 1'b0;
    // Controller wins at ID bit 40
    base_row(rows[5], 1'b0, 1'b0, 7'h3a);
    rows[5].main_id[40] = 1'b1;
    rows[5].comp_en     = 1'b1;
    rows[5].comp_id     = ~(64'd1 << 40);
    rows[5].addr_acked  = 1'b0;
    // Bit before the STOP is a 1 so the bus is released
    base_row(rows[6], 1'b0, 1'b0, 7'h19);
    rows[6].stop_at     = 20;
    rows[6].main_id[44] = 1'b1;
    base_row(rows[7], 1'b0, 1'b0, 7'h55);
    rows[7].main_valid = 1'b1;
    rows[7].main_addr  = 7'h55;
    base_row(rows[8], 1'b1, 1'b1, 7'h0a);
    rows[8].main_valid = 1'b1;
    rows[8].main_addr  = 7'h0a;
    base_row(rows[9], 1'b0, 1'b1, 7'h6b);
    rows[9].answer_virt = 1'b1;
    rows[9].main_valid  = 1'b1;
    rows[9].main_addr   = 7'h0a;
    rows[9].virt_valid  = 1'b1;
    rows[9].virt_addr   = 7'h6b;
    base_row(rows[10], 1'b0, 1'b1, 7'h2f);
    rows[10].rsvd_acked  = 1'b0;
    rows[10].addr_acked  = 1'b0;
    rows[10].done_pulses = 0;
    rows[10].main_valid  = 1'b1;
    rows[10].main_addr   = 7'h0a;
    rows[10].virt_valid  = 1'b1;
    rows[10].virt_addr   = 7'h6b;
  endtask

  task automatic run_round(input row_t r);
    logic        seen;
    logic        ctrl_bit;
    logic        tgt_bit;
    logic        lost;
    logic        stopped;
    logic [63:0] id;
    logic [7:0]  addr_byte;
    int          done_before;
    wait_clocks(1);
    virt_en     = r.virt_en;
    main_id     = r.main_id;
    virt_id     = r.virt_id;
    done_before = done_count;
    start_daa   = 1'b1;
    wait_clocks(1);
    start_daa = 1'b0;
    issue_start();
    for (int n = 7; n >= 0; n--) clock_bit(r.rsvd_byte[n], seen);
    clock_bit(1'b1, seen);
    check_value(64'(seen), 64'(!r.rsvd_acked), "reserved byte ACK slot");
    id      = r.answer_virt ? r.virt_id : r.main_id;
    lost    = !r.rsvd_acked;
    stopped = 1'b0;
    for (int n = 0; n < 64 && !stopped; n++) begin
      if (n == r.stop_at) begin
        break_with_stop();
        stopped = 1'b1;
      end else begin
        ctrl_bit = r.comp_en ? r.comp_id[63-n] : 1'b1;
        tgt_bit  = lost ? 1'b1 : id[63-n];
        clock_bit(ctrl_bit, seen);
        check_value(64'(seen), 64'(ctrl_bit & tgt_bit), "ID bit on SDA");
        // A released 1 against a driven 0 drops the target out
        if (tgt_bit && !ctrl_bit) lost = 1'b1;
      end
    end
    if (!stopped) begin
      addr_byte = {r.addr, (~^r.addr) ^ r.bad_par};
      for (int n = 7; n >= 0; n--) clock_bit(addr_byte[n], seen);
      clock_bit(1'b1, seen);
      check_value(64'(seen), 64'(!r.addr_acked), "address ACK slot");
      issue_stop();
    end
    wait_clocks(10);
    check_value(64'(sda_oe), 64'd0, "SDA released after round");
    check_value(64'(done_count - done_before), 64'(r.done_pulses), "daa_done pulses");
    check_value(64'(addr_valid), 64'(r.main_valid), "main slot valid");
    if (r.main_valid) check_value(64'(addr), 64'(r.main_addr), "main address");
    check_value(64'(virt_addr_valid), 64'(r.virt_valid), "virtual slot valid");
    if (r.virt_valid) check_value(64'(virt_addr), 64'(r.virt_addr), "virtual address");
  endtask

  initial begin
    rst_ni    = 1'b0;
    scl       = 1'b1;
    sda_ctrl  = 1'b1;
    start_daa = 1'b0;
    virt_en   = 1'b0;
    main_id   = '0;
    virt_id   = '0;
    build_table();
    wait_clocks(2);
    rst_ni = 1'b1;
    for (int k = 0; k < NumRows; k++) begin
      if (rows[k].reset_before) apply_reset();
      run_round(rows[k]);
    end
    $display("TEST OK");
    $finish;
  end

endmodule

// ==== i3c_daa_target.f ====
rtl/i3c_daa_pkg.sv
rtl/bus_monitor.sv
rtl/bus_rx.sv
rtl/bus_tx.sv
rtl/ccc_entdaa.sv
rtl/daa_addr_table.sv
rtl/i3c_daa_target.sv
tests/tb_i3c_daa_target.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
  -f i3c_daa_target.f --top-module tb_i3c_daa_target -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
  exit 1
fi
if ! grep -q "TEST OK" sim.log; then
  echo "Simulation ended without a result line"
  exit 1
fi
